// ==== vex_consts.svh ====
`ifndef VEX_CONSTS_SVH
`define VEX_CONSTS_SVH

// lanes working side by side
`define VEX_NUM_LANES 4

// vector registers held in each lane bank
`define VEX_NUM_VREGS 8

// element and scalar width
`define VEX_XLEN 32

`endif

// ==== vex_pkg.sv ====
`include "vex_consts.svh"

package vex_pkg;

    // one element or scalar operand
    typedef logic [`VEX_XLEN-1:0] word_t;

    // selects one of the vector registers
    typedef logic [$clog2(`VEX_NUM_VREGS)-1:0] vreg_idx_t;

    // lane ops, reductions last
    typedef enum logic [3:0] {
        VALU_ADD,
        VALU_SUB,
        VALU_AND,
        VALU_OR,
        VALU_XOR,
        VALU_MIN,
        VALU_MAX,
        VALU_MINU,
        VALU_MAXU,
        // mask-set compares, 0 or 1 per lane
        VALU_SEQ,
        VALU_SLT,
        VALU_MV,
        VALU_VID,
        VALU_REDSUM,
        VALU_REDMAX,
        VALU_REDAND
    } valu_op_e;

    // control that rides along with the lane results
    typedef struct packed {
        logic      valid;
        valu_op_e  op;
        vreg_idx_t vd;
    } vex_ctrl_t;

endpackage

// ==== lane_op_if.sv ====
`timescale 1ns/1ps

// operand bundle for one lane, filled by operand_select
interface lane_op_if;

    // vs2 side
    vex_pkg::word_t opa;
    // vs1, rs1 or immediate
    vex_pkg::word_t opb;
    logic mask_bit;
    vex_pkg::valu_op_e op;
    logic valid;

    modport feed (
        output opa,
        output opb,
        output mask_bit,
        output op,
        output valid
    );

    modport lane (
        input opa,
        input opb,
        input mask_bit,
        input op,
        input valid
    );

endinterface

// ==== vector_bank.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module vector_bank (
    input  logic              CLK,
    input  logic              rst_n,
    input  vex_pkg::vreg_idx_t rd_a,
    input  vex_pkg::vreg_idx_t rd_b,
    input  vex_pkg::vreg_idx_t wr_idx,
    input  logic              wr_en,
    input  vex_pkg::word_t    wr_data,
    output vex_pkg::word_t    dat_a,
    output vex_pkg::word_t    dat_b,
    output logic              v0_bit
);

    // this lane's slice of every vector register
    vex_pkg::word_t regs [`VEX_NUM_VREGS];

    // banks come out of reset holding zeros
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `VEX_NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // read ports are combinational, no bypass from the write port
    assign dat_a = regs[rd_a];
    assign dat_b = regs[rd_b];

    // v0 bit 0 is this lane's mask bit
    assign v0_bit = regs[0][0];

endmodule

// ==== operand_select.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module operand_select (
    input  vex_pkg::word_t                        rs1,
    input  logic [4:0]                            imm,
    input  logic                                  use_imm,
    input  logic                                  use_rs1,
    input  logic                                  mask_en,
    input  logic                                  issue,
    input  vex_pkg::valu_op_e                     op,
    // vs2 read data, lane 0 in the low word
    input  vex_pkg::word_t [`VEX_NUM_LANES-1:0]   src_a,
    // vs1 read data
    input  vex_pkg::word_t [`VEX_NUM_LANES-1:0]   src_b,
    input  logic [`VEX_NUM_LANES-1:0]             v0_bits,
    lane_op_if.feed                               lanes [`VEX_NUM_LANES]
);

    vex_pkg::word_t ext_imm;
    vex_pkg::word_t scalar_b;
    logic use_scalar;
    logic [`VEX_NUM_LANES-1:0] lane_mask;

    // 5-bit immediate is always sign-extended here
    assign ext_imm = {{(`VEX_XLEN-5){imm[4]}}, imm};

    // immediate wins over rs1 when both are set
    always_comb begin
        use_scalar = use_imm | use_rs1;
        scalar_b = rs1;
        if (use_imm) begin
            scalar_b = ext_imm;
        end
    end

    // unmasked ops see every lane enabled
    assign lane_mask = mask_en ? v0_bits : '1;

    genvar g;
    generate
        for (g = 0; g < `VEX_NUM_LANES; g++) begin : g_feed
            assign lanes[g].opa = src_a[g];
            // scalar broadcast or per-lane vs1
            assign lanes[g].opb = use_scalar ? scalar_b : src_b[g];
            assign lanes[g].mask_bit = lane_mask[g];
            assign lanes[g].op = op;
            assign lanes[g].valid = issue;
        end
    endgenerate

endmodule

// ==== lane_alu.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module lane_alu #(
    parameter int LANE_IDX = 0
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    lane_op_if.lane              lop,
    input  vex_pkg::vreg_idx_t   vd,
    output vex_pkg::word_t       res,
    output logic                 res_mask,
    output vex_pkg::vex_ctrl_t   ctrl
);

    localparam vex_pkg::word_t MOST_NEG = {1'b1, {(`VEX_XLEN-1){1'b0}}};

    vex_pkg::word_t alu_res;
    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(lop.opa) < $signed(lop.opb);
    assign lt_u = lop.opa < lop.opb;

    always_comb begin
        alu_res = lop.opa;
        case (lop.op)
            vex_pkg::VALU_ADD:  alu_res = lop.opa + lop.opb;
            vex_pkg::VALU_SUB:  alu_res = lop.opa - lop.opb;
            vex_pkg::VALU_AND:  alu_res = lop.opa & lop.opb;
            vex_pkg::VALU_OR:   alu_res = lop.opa | lop.opb;
            vex_pkg::VALU_XOR:  alu_res = lop.opa ^ lop.opb;
            vex_pkg::VALU_MIN:  alu_res = lt_s ? lop.opa : lop.opb;
            vex_pkg::VALU_MAX:  alu_res = lt_s ? lop.opb : lop.opa;
            vex_pkg::VALU_MINU: alu_res = lt_u ? lop.opa : lop.opb;
            vex_pkg::VALU_MAXU: alu_res = lt_u ? lop.opb : lop.opa;
            // compares produce a single 0/1 per lane
            vex_pkg::VALU_SEQ:  alu_res = vex_pkg::word_t'(lop.opa == lop.opb);
            vex_pkg::VALU_SLT:  alu_res = vex_pkg::word_t'(lt_s);
            vex_pkg::VALU_MV:   alu_res = lop.opb;
            vex_pkg::VALU_VID:  alu_res = vex_pkg::word_t'(LANE_IDX);
            // masked-off lanes feed the fold's identity
            vex_pkg::VALU_REDSUM: begin
                alu_res = lop.mask_bit ? lop.opa : '0;
            end
            vex_pkg::VALU_REDMAX: begin
                alu_res = lop.mask_bit ? lop.opa : MOST_NEG;
            end
            vex_pkg::VALU_REDAND: begin
                alu_res = lop.mask_bit ? lop.opa : '1;
            end
            default: alu_res = lop.opa;
        endcase
    end

    // result word, captured every cycle
    always_ff @(posedge CLK) begin
        res <= alu_res;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
            res_mask <= 1'b0;
        end else begin
            ctrl.valid <= lop.valid;
            ctrl.op <= lop.op;
            ctrl.vd <= vd;
            // no write when nothing was issued
            res_mask <= lop.valid & lop.mask_bit;
        end
    end

endmodule

// ==== result_collect.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module result_collect (
    input  logic                                      CLK,
    input  logic                                      rst_n,
    input  vex_pkg::word_t [`VEX_NUM_LANES-1:0]       lane_res,
    input  logic [`VEX_NUM_LANES-1:0]                 lane_mask,
    input  vex_pkg::vex_ctrl_t                        ctrl,
    output logic                                      res_valid,
    output vex_pkg::vreg_idx_t                        res_vd,
    output logic [`VEX_NUM_LANES*`VEX_XLEN-1:0]       res_data,
    output logic [`VEX_NUM_LANES-1:0]                 res_wmask,
    output vex_pkg::word_t                            red_res,
    output logic [`VEX_NUM_LANES-1:0]                 bank_wr_en
);

    localparam logic [`VEX_NUM_LANES-1:0] LANE0_ONLY = 1;

    logic is_red;
    vex_pkg::word_t red_sum;
    vex_pkg::word_t red_max;
    vex_pkg::word_t red_and;
    vex_pkg::word_t fold;
    logic [`VEX_NUM_LANES*`VEX_XLEN-1:0] merged;
    logic [`VEX_NUM_LANES-1:0] wmask;

    assign is_red = ctrl.op inside {vex_pkg::VALU_REDSUM, vex_pkg::VALU_REDMAX,
                                    vex_pkg::VALU_REDAND};

    // lanes already padded masked inputs with the identity
    always_comb begin
        red_sum = lane_res[0];
        red_max = lane_res[0];
        red_and = lane_res[0];
        for (int i = 1; i < `VEX_NUM_LANES; i++) begin
            red_sum = red_sum + lane_res[i];
            red_and = red_and & lane_res[i];
            if ($signed(lane_res[i]) > $signed(red_max)) begin
                red_max = lane_res[i];
            end
        end
    end

    always_comb begin
        case (ctrl.op)
            vex_pkg::VALU_REDSUM: fold = red_sum;
            vex_pkg::VALU_REDMAX: fold = red_max;
            vex_pkg::VALU_REDAND: fold = red_and;
            default:              fold = '0;
        endcase
    end

    // reductions land in lane 0 only
    always_comb begin
        merged = lane_res;
        wmask = lane_mask;
        if (is_red) begin
            merged = '0;
            merged[`VEX_XLEN-1:0] = fold;
            wmask = LANE0_ONLY;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            res_wmask <= '0;
        end else begin
            res_valid <= ctrl.valid;
            res_wmask <= ctrl.valid ? wmask : '0;
        end
    end

    always_ff @(posedge CLK) begin
        res_vd <= ctrl.vd;
        res_data <= merged;
        red_res <= fold;
    end

    // write-back happens in the same cycle as res_valid
    assign bank_wr_en = res_wmask & {`VEX_NUM_LANES{res_valid}};

endmodule

// ==== vex_top.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module vex_top (
    input  logic                                 CLK,
    input  logic                                 rst_n,
    input  logic                                 issue,
    input  vex_pkg::valu_op_e                    op,
    input  vex_pkg::vreg_idx_t                   vs1,
    input  vex_pkg::vreg_idx_t                   vs2,
    input  vex_pkg::vreg_idx_t                   vd,
    input  logic [4:0]                           imm,
    input  logic                                 use_imm,
    input  vex_pkg::word_t                       rs1,
    input  logic                                 use_rs1,
    input  logic                                 mask_en,
    output logic                                 res_valid,
    output vex_pkg::vreg_idx_t                   res_vd,
    output logic [`VEX_NUM_LANES*`VEX_XLEN-1:0]  res_data,
    output logic [`VEX_NUM_LANES-1:0]            res_wmask,
    output vex_pkg::word_t                       red_res
);

    vex_pkg::word_t [`VEX_NUM_LANES-1:0] vs2_dat;
    vex_pkg::word_t [`VEX_NUM_LANES-1:0] vs1_dat;
    vex_pkg::word_t [`VEX_NUM_LANES-1:0] lane_res;
    logic [`VEX_NUM_LANES-1:0] v0_bits;
    logic [`VEX_NUM_LANES-1:0] lane_mask;
    logic [`VEX_NUM_LANES-1:0] bank_wr_en;
    // all lanes carry the same control, lane 0 drives the collector
    vex_pkg::vex_ctrl_t lane_ctrl [`VEX_NUM_LANES];

    lane_op_if lane_ops [`VEX_NUM_LANES] ();

    genvar g;
    generate
        for (g = 0; g < `VEX_NUM_LANES; g++) begin : g_bank
            vector_bank i_vector_bank (
                .CLK(CLK), .rst_n(rst_n),
                .rd_a(vs2), .rd_b(vs1),
                .wr_idx(res_vd), .wr_en(bank_wr_en[g]),
                .wr_data(res_data[g*`VEX_XLEN +: `VEX_XLEN]),
                .dat_a(vs2_dat[g]), .dat_b(vs1_dat[g]),
                .v0_bit(v0_bits[g])
            );
        end
    endgenerate

    operand_select i_operand_select (
        .rs1(rs1), .imm(imm), .use_imm(use_imm), .use_rs1(use_rs1),
        .mask_en(mask_en), .issue(issue), .op(op),
        .src_a(vs2_dat), .src_b(vs1_dat), .v0_bits(v0_bits),
        .lanes(lane_ops)
    );

    generate
        for (g = 0; g < `VEX_NUM_LANES; g++) begin : g_lane
            lane_alu #(.LANE_IDX(g)) i_lane_alu (
                .CLK(CLK), .rst_n(rst_n), .lop(lane_ops[g]), .vd(vd),
                .res(lane_res[g]), .res_mask(lane_mask[g]), .ctrl(lane_ctrl[g])
            );
        end
    endgenerate

    result_collect i_result_collect (
        .CLK(CLK), .rst_n(rst_n),
        .lane_res(lane_res), .lane_mask(lane_mask), .ctrl(lane_ctrl[0]),
        .res_valid(res_valid), .res_vd(res_vd), .res_data(res_data),
        .res_wmask(res_wmask), .red_res(red_res), .bank_wr_en(bank_wr_en)
    );

endmodule

// ==== vex_chk.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module vex_chk (
    input logic                      CLK,
    input logic                      rst_n,
    input logic                      issue,
    input vex_pkg::valu_op_e         op,
    input logic                      res_valid,
    input logic [`VEX_NUM_LANES-1:0] res_wmask
);

    // assertion failures so far
    int fail_count = 0;
    logic red_issue;

    assign red_issue = issue && (op inside {vex_pkg::VALU_REDSUM, vex_pkg::VALU_REDMAX,
                                            vex_pkg::VALU_REDAND});

    // fixed two-cycle latency
    a_issue_to_valid: assert property (@(posedge CLK) disable iff (!rst_n)
        issue |-> ##2 res_valid)
        else begin
            fail_count++;
            $error("res_valid did not follow an issue after two cycles");
        end

    // no result without an issue two cycles back
    a_valid_has_issue: assert property (@(posedge CLK) disable iff (!rst_n)
        res_valid |-> $past(issue, 2))
        else begin
            fail_count++;
            $error("res_valid pulsed without an issue two cycles earlier");
        end

    a_quiet_in_reset: assert property (@(posedge CLK) !rst_n |-> !res_valid)
        else begin
            fail_count++;
            $error("res_valid high while reset is asserted");
        end

    // reductions only ever write lane 0
    a_red_lane0: assert property (@(posedge CLK) disable iff (!rst_n)
        red_issue |-> ##2 (res_wmask == 4'b0001))
        else begin
            fail_count++;
            $error("reduction write mask is not lane 0 only");
        end

endmodule

// ==== tb_vex.sv ====
`timescale 1ns/1ps

`include "vex_consts.svh"

module tb_vex;

    logic CLK = 1'b0;
    logic rst_n;
    logic issue;
    vex_pkg::valu_op_e op;
    vex_pkg::vreg_idx_t vs1;
    vex_pkg::vreg_idx_t vs2;
    vex_pkg::vreg_idx_t vd;
    logic [4:0] imm;
    logic use_imm;
    vex_pkg::word_t rs1;
    logic use_rs1;
    logic mask_en;
    logic res_valid;
    vex_pkg::vreg_idx_t res_vd;
    logic [`VEX_NUM_LANES*`VEX_XLEN-1:0] res_data;
    logic [`VEX_NUM_LANES-1:0] res_wmask;
    vex_pkg::word_t red_res;

    // reference copy of every lane bank
    vex_pkg::word_t model [`VEX_NUM_LANES][`VEX_NUM_VREGS];
    // expected results of ops in flight
    logic [`VEX_NUM_LANES*`VEX_XLEN-1:0] exp_data_q [$];
    logic [`VEX_NUM_LANES-1:0] exp_wmask_q [$];
    vex_pkg::word_t exp_red_q [$];
    vex_pkg::vreg_idx_t exp_vd_q [$];
    bit exp_isred_q [$];

    string test_name;
    int errors = 0;
    int errors_at_start = 0;
    int tests_ok = 0;
    int tests_bad = 0;

    vex_top i_vex_top (
        .CLK(CLK), .rst_n(rst_n), .issue(issue), .op(op),
        .vs1(vs1), .vs2(vs2), .vd(vd), .imm(imm), .use_imm(use_imm),
        .rs1(rs1), .use_rs1(use_rs1), .mask_en(mask_en),
        .res_valid(res_valid), .res_vd(res_vd), .res_data(res_data),
        .res_wmask(res_wmask), .red_res(red_res)
    );

    bind vex_top vex_chk i_vex_chk (
        .CLK(CLK), .rst_n(rst_n), .issue(issue), .op(op),
        .res_valid(res_valid), .res_wmask(res_wmask)
    );

    always #10 CLK = ~CLK;

    function automatic vex_pkg::word_t ref_lane(input vex_pkg::valu_op_e o,
                                                input vex_pkg::word_t a,
                                                input vex_pkg::word_t b, input int lane);
        logic slt;
        logic ult;
        slt = $signed(a) < $signed(b);
        ult = a < b;
        case (o)
            vex_pkg::VALU_ADD:  return a + b;
            vex_pkg::VALU_SUB:  return a - b;
            vex_pkg::VALU_AND:  return a & b;
            vex_pkg::VALU_OR:   return a | b;
            vex_pkg::VALU_XOR:  return a ^ b;
            vex_pkg::VALU_MIN:  return slt ? a : b;
            vex_pkg::VALU_MAX:  return slt ? b : a;
            vex_pkg::VALU_MINU: return ult ? a : b;
            vex_pkg::VALU_MAXU: return ult ? b : a;
            vex_pkg::VALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
            vex_pkg::VALU_SLT:  return slt ? 32'd1 : 32'd0;
            vex_pkg::VALU_MV:   return b;
            vex_pkg::VALU_VID:  return vex_pkg::word_t'(lane);
            default:            return a;
        endcase
    endfunction

    // value that leaves a fold unchanged
    function automatic vex_pkg::word_t red_identity(input vex_pkg::valu_op_e o);
        case (o)
            vex_pkg::VALU_REDMAX: return 32'h8000_0000;
            vex_pkg::VALU_REDAND: return 32'hffff_ffff;
            default:              return 32'd0;
        endcase
    endfunction

    function automatic vex_pkg::word_t red_combine(input vex_pkg::valu_op_e o,
                                                   input vex_pkg::word_t acc,
                                                   input vex_pkg::word_t x);
        case (o)
            vex_pkg::VALU_REDMAX: return ($signed(x) > $signed(acc)) ? x : acc;
            vex_pkg::VALU_REDAND: return acc & x;
            default:              return acc + x;
        endcase
    endfunction

    function automatic vex_pkg::vreg_idx_t rand_reg(input int lo, input int hi);
        return vex_pkg::vreg_idx_t'($urandom_range(hi, lo));
    endfunction

    task automatic report_mismatch(input string what, input vex_pkg::word_t expv,
                                   input vex_pkg::word_t actv);
        $display("error %s: %s expected %h actual %h", test_name, what, expv, actv);
        errors++;
    endtask

    // checks one result if res_valid is up and updates the model
    task automatic poll_result();
        logic [`VEX_NUM_LANES*`VEX_XLEN-1:0] e_data;
        logic [`VEX_NUM_LANES-1:0] e_wm;
        vex_pkg::word_t e_red;
        vex_pkg::vreg_idx_t e_vd;
        bit e_isred;
        if (res_valid !== 1'b1) begin
            return;
        end
        if (exp_vd_q.size() == 0) begin
            $display("res_valid pulsed with no op in flight in test %s", test_name);
            errors++;
            return;
        end
        e_data = exp_data_q.pop_front();
        e_wm = exp_wmask_q.pop_front();
        e_red = exp_red_q.pop_front();
        e_vd = exp_vd_q.pop_front();
        e_isred = exp_isred_q.pop_front();
        assert (res_vd === e_vd)
            else report_mismatch("res_vd", vex_pkg::word_t'(e_vd), vex_pkg::word_t'(res_vd));
        assert (res_wmask === e_wm)
            else report_mismatch("res_wmask", vex_pkg::word_t'(e_wm),
                                 vex_pkg::word_t'(res_wmask));
        if (e_isred) begin
            assert (red_res === e_red) else report_mismatch("red_res", e_red, red_res);
            assert (res_data[`VEX_XLEN-1:0] === e_data[`VEX_XLEN-1:0])
                else report_mismatch("res_data lane 0", e_data[`VEX_XLEN-1:0],
                                     res_data[`VEX_XLEN-1:0]);
        end else begin
            for (int i = 0; i < `VEX_NUM_LANES; i++) begin
                assert (res_data[i*`VEX_XLEN +: `VEX_XLEN] === e_data[i*`VEX_XLEN +: `VEX_XLEN])
                    else report_mismatch($sformatf("res_data lane %0d", i),
                                         e_data[i*`VEX_XLEN +: `VEX_XLEN],
                                         res_data[i*`VEX_XLEN +: `VEX_XLEN]);
            end
        end
        // banks take the result where the write mask is set
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            if (e_wm[i]) begin
                model[i][e_vd] = e_data[i*`VEX_XLEN +: `VEX_XLEN];
            end
        end
    endtask

    // kind 0 takes vs1, 1 takes rs1, 2 takes the immediate
    task automatic issue_op(input vex_pkg::valu_op_e o, input vex_pkg::vreg_idx_t s1,
                            input vex_pkg::vreg_idx_t s2, input vex_pkg::vreg_idx_t d,
                            input logic [1:0] kind, input vex_pkg::word_t sc,
                            input logic [4:0] im, input logic m_en);
        vex_pkg::word_t a;
        vex_pkg::word_t b;
        vex_pkg::word_t acc;
        logic [`VEX_NUM_LANES*`VEX_XLEN-1:0] data;
        logic [`VEX_NUM_LANES-1:0] wm;
        logic mb;
        bit red;
        red = o inside {vex_pkg::VALU_REDSUM, vex_pkg::VALU_REDMAX, vex_pkg::VALU_REDAND};
        acc = red_identity(o);
        data = '0;
        wm = '0;
        @(negedge CLK);
        poll_result();
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            a = model[i][s2];
            case (kind)
                2'd1:    b = sc;
                // negative immediates lie 32 below their unsigned code
                2'd2:    b = vex_pkg::word_t'(im) - (im[4] ? 32'd32 : 32'd0);
                default: b = model[i][s1];
            endcase
            mb = m_en ? model[i][0][0] : 1'b1;
            if (red) begin
                acc = red_combine(o, acc, mb ? a : red_identity(o));
            end else begin
                data[i*`VEX_XLEN +: `VEX_XLEN] = ref_lane(o, a, b, i);
                wm[i] = mb;
            end
        end
        if (red) begin
            data[`VEX_XLEN-1:0] = acc;
            wm = 4'b0001;
        end
        exp_data_q.push_back(data);
        exp_wmask_q.push_back(wm);
        exp_red_q.push_back(acc);
        exp_vd_q.push_back(d);
        exp_isred_q.push_back(red);
        issue = 1'b1;
        op = o;
        vs1 = s1;
        vs2 = s2;
        vd = d;
        use_rs1 = (kind == 2'd1);
        use_imm = (kind == 2'd2);
        rs1 = sc;
        imm = im;
        mask_en = m_en;
    endtask

    task automatic wait_results();
        int cycles;
        cycles = 0;
        while (exp_vd_q.size() != 0) begin
            @(negedge CLK);
            issue = 1'b0;
            poll_result();
            cycles++;
            if (cycles > 8 && exp_vd_q.size() != 0) begin
                $display("timeout waiting for res_valid in test %s", test_name);
                $display("TEST FAIL");
                $finish;
            end
        end
    endtask

    // v0 pattern from vid < k and an optional inversion
    task automatic set_mask();
        issue_op(vex_pkg::VALU_SLT, 3'd0, 3'd7, 3'd0, 2'd1,
                 vex_pkg::word_t'($urandom_range(4, 0)), 5'd0, 1'b0);
        wait_results();
        issue_op(vex_pkg::VALU_XOR, 3'd0, 3'd0, 3'd0, 2'd2, 32'd0,
                 5'($urandom_range(1, 0)), 1'b0);
        wait_results();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
            tests_ok++;
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
            tests_bad++;
        end
    endtask

    initial begin
        vex_pkg::valu_op_e elem_ops [9];
        vex_pkg::valu_op_e red_ops [3];
        vex_pkg::vreg_idx_t d;
        vex_pkg::vreg_idx_t s2;
        elem_ops = '{vex_pkg::VALU_ADD, vex_pkg::VALU_SUB, vex_pkg::VALU_AND,
                     vex_pkg::VALU_OR, vex_pkg::VALU_XOR, vex_pkg::VALU_MIN,
                     vex_pkg::VALU_MAX, vex_pkg::VALU_MINU, vex_pkg::VALU_MAXU};
        red_ops = '{vex_pkg::VALU_REDSUM, vex_pkg::VALU_REDMAX, vex_pkg::VALU_REDAND};
        void'($urandom(32'hff87));
        rst_n = 1'b1;
        issue = 1'b0;
        op = vex_pkg::VALU_ADD;
        vs1 = '0;
        vs2 = '0;
        vd = '0;
        imm = '0;
        use_imm = 1'b0;
        rs1 = '0;
        use_rs1 = 1'b0;
        mask_en = 1'b0;
        for (int i = 0; i < `VEX_NUM_LANES; i++) begin
            for (int r = 0; r < `VEX_NUM_VREGS; r++) begin
                model[i][r] = '0;
            end
        end
        #1 rst_n = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;

        start_test("loading");
        issue_op(vex_pkg::VALU_MV, 3'd2, 3'd2, 3'd5, 2'd0, 32'd0, 5'd0, 1'b0);
        wait_results();
        for (int i = 1; i < 7; i++) begin
            issue_op(vex_pkg::VALU_MV, 3'd0, 3'd0, vex_pkg::vreg_idx_t'(i), 2'd1,
                     $urandom, 5'd0, 1'b0);
            wait_results();
        end
        issue_op(vex_pkg::VALU_VID, 3'd0, 3'd0, 3'd7, 2'd0, 32'd0, 5'd0, 1'b0);
        wait_results();
        end_test();

        start_test("element_ops");
        // masked moves make the lanes differ
        for (int i = 1; i < 7; i++) begin
            set_mask();
            issue_op(vex_pkg::VALU_MV, 3'd0, 3'd0, vex_pkg::vreg_idx_t'(i), 2'd1,
                     $urandom, 5'd0, 1'b1);
            wait_results();
        end
        for (int k = 0; k < 9; k++) begin
            for (int kind = 0; kind < 3; kind++) begin
                issue_op(elem_ops[k], rand_reg(1, 7), rand_reg(1, 7), rand_reg(1, 6),
                         2'(kind), $urandom, 5'($urandom), 1'b0);
                wait_results();
            end
        end
        end_test();

        start_test("compares");
        for (int i = 0; i < 12; i++) begin
            s2 = rand_reg(1, 7);
            issue_op(($urandom_range(1, 0) == 0) ? vex_pkg::VALU_SEQ : vex_pkg::VALU_SLT,
                     ($urandom_range(1, 0) == 0) ? s2 : rand_reg(1, 7), s2, rand_reg(1, 6),
                     2'($urandom_range(2, 0)),
                     ($urandom_range(1, 0) == 0) ? model[0][s2] : $urandom,
                     5'($urandom), 1'b0);
            wait_results();
        end
        end_test();

        start_test("masking");
        for (int i = 0; i < 8; i++) begin
            set_mask();
            d = rand_reg(1, 6);
            issue_op(elem_ops[$urandom_range(8, 0)], rand_reg(1, 7), rand_reg(1, 7), d,
                     2'($urandom_range(2, 0)), $urandom, 5'($urandom), 1'b1);
            wait_results();
            // read back through an unmasked move onto itself
            issue_op(vex_pkg::VALU_MV, d, d, d, 2'd0, 32'd0, 5'd0, 1'b0);
            wait_results();
        end
        end_test();

        start_test("reductions");
        for (int i = 0; i < 9; i++) begin
            set_mask();
            issue_op(red_ops[i % 3], rand_reg(1, 7), rand_reg(1, 7), rand_reg(1, 6), 2'd0,
                     32'd0, 5'd0, 1'($urandom_range(1, 0)));
            wait_results();
        end
        end_test();

        start_test("back_to_back");
        // sources 1..3 and vid with results into 4..6 keep the ops independent
        for (int i = 0; i < 16; i++) begin
            s2 = rand_reg(1, 4);
            d = rand_reg(1, 4);
            issue_op(vex_pkg::valu_op_e'($urandom_range(15, 0)), (d == 3'd4) ? 3'd7 : d,
                     (s2 == 3'd4) ? 3'd7 : s2, rand_reg(4, 6), 2'($urandom_range(2, 0)),
                     $urandom, 5'($urandom), 1'($urandom_range(1, 0)));
        end
        wait_results();
        end_test();

        errors += i_vex_top.i_vex_chk.fail_count;
        $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
vex_pkg.sv
lane_op_if.sv
vector_bank.sv
operand_select.sv
lane_alu.sv
result_collect.sv
vex_top.sv
vex_chk.sv
tb_vex.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vex
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
